/* hdl/sram_pkg.sv */
package sram_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	// one strobe per data byte
	localparam int STRB_W = DATA_W / 8;

	// 4 KiB window starting at address 0
	localparam int MEM_WORDS = 512;
	// word index, byte offset bits dropped
	localparam int IDX_W = 9;

	// wait cycles for every valid access
	localparam int ACCESS_WAIT = 2;
	// timer counter width, holds ACCESS_WAIT down to zero
	localparam int TMR_W = $clog2(ACCESS_WAIT + 1);

	// response codes on rresp and bresp
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_t;

	// controller states
	typedef enum logic [2:0] {
		// waiting for a request, write wins
		IDLE,
		// write accepted, timer running
		WR_WAIT,
		// write response on the b channel
		WR_RESP,
		// read accepted, timer running
		RD_WAIT,
		// array word on its way out
		RD_DATA,
		// read data on the r channel
		RD_RESP,
		// slverr on r or b, no array access
		ERR_RESP
	} ctrl_state_t;

endpackage

/* hdl/wait_timer.sv */
`timescale 1ns/1ps

module wait_timer
	import sram_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic done
);

	// zero means idle
	logic [TMR_W-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (start) begin
			// load the full wait
			count <= TMR_W'(ACCESS_WAIT);
		end else if (count != '0) begin
			count <= count - TMR_W'(1);
		end
	end

	// last cycle before zero, ACCESS_WAIT cycles after start
	assign done = (count == TMR_W'(1));

	// controller only starts from idle, so no restart mid-count
	a_no_restart: assert property (@(posedge clk) disable iff (rst)
		start |-> (count == '0));

endmodule

/* hdl/sram_array.sv */
`timescale 1ns/1ps

module sram_array
	import sram_pkg::*;
(
	input  logic              clk,
	// write port
	input  logic              we,
	input  logic [IDX_W-1:0]  widx,
	input  logic [DATA_W-1:0] wdata,
	input  logic [STRB_W-1:0] wstrb,
	// read port
	input  logic              re,
	input  logic [IDX_W-1:0]  ridx,
	output logic [DATA_W-1:0] rdata
);

	// word storage, contents start undefined
	logic [DATA_W-1:0] mem [MEM_WORDS];

	// byte-strobed write
	always_ff @(posedge clk) begin
		if (we) begin
			for (int b = 0; b < STRB_W; b++) begin
				// only strobed bytes change
				if (wstrb[b]) begin
					mem[widx][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
	end

	// registered read, word valid the cycle after re
	always_ff @(posedge clk) begin
		if (re) begin
			rdata <= mem[ridx];
		end
	end

endmodule

/* hdl/sram_ctrl.sv */
`timescale 1ns/1ps

module sram_ctrl
	import sram_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	// read address channel
	input  logic              arvalid,
	input  logic [ADDR_W-1:0] araddr,
	output logic              arready,
	// read data channel
	output logic              rvalid,
	output logic [DATA_W-1:0] rdata,
	output resp_t             rresp,
	input  logic              rready,
	// write address and data
	input  logic              awvalid,
	input  logic [ADDR_W-1:0] awaddr,
	output logic              awready,
	input  logic              wvalid,
	input  logic [DATA_W-1:0] wdata,
	input  logic [STRB_W-1:0] wstrb,
	output logic              wready,
	// write response channel
	output logic              bvalid,
	output resp_t             bresp,
	input  logic              bready,
	// latency timer
	output logic              tmr_start,
	input  logic              tmr_done,
	// array ports
	output logic              mem_we,
	output logic [IDX_W-1:0]  mem_widx,
	output logic [DATA_W-1:0] mem_wdata,
	output logic [STRB_W-1:0] mem_wstrb,
	output logic              mem_re,
	output logic [IDX_W-1:0]  mem_ridx,
	input  logic [DATA_W-1:0] mem_rdata
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	// low during reset, keeps the readys down
	logic live;
	// the pending error belongs to a read
	logic err_rd;
	logic idle;
	logic wr_take;
	logic rd_take;
	logic [ADDR_W-1:0] req_addr;
	logic req_ok;
	// latched request and response payload
	logic [IDX_W-1:0] idx_q;
	logic [DATA_W-1:0] wdata_q;
	logic [STRB_W-1:0] wstrb_q;
	logic [DATA_W-1:0] rdata_q;
	resp_t resp_q;

	assign idle = live && (state == IDLE);

	// write needs both valids, read only goes when no write is pending
	assign wr_take = idle && awvalid && wvalid;
	assign rd_take = idle && arvalid && !(awvalid && wvalid);

	// address of whichever request is taken this cycle
	assign req_addr = wr_take ? awaddr : araddr;
	// 8-byte aligned and inside the window
	assign req_ok = (req_addr[2:0] == 3'b000) && (req_addr[ADDR_W-1:IDX_W+3] == '0);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (wr_take) begin
					state_nxt = req_ok ? WR_WAIT : ERR_RESP;
				end else if (rd_take) begin
					state_nxt = req_ok ? RD_WAIT : ERR_RESP;
				end
			end
			WR_WAIT: begin
				// commit happens on this same edge
				if (tmr_done) begin
					state_nxt = WR_RESP;
				end
			end
			WR_RESP: begin
				if (bready) begin
					state_nxt = IDLE;
				end
			end
			RD_WAIT: begin
				if (tmr_done) begin
					state_nxt = RD_DATA;
				end
			end
			RD_DATA: begin
				// array word lands in rdata_q
				state_nxt = RD_RESP;
			end
			RD_RESP: begin
				if (rready) begin
					state_nxt = IDLE;
				end
			end
			ERR_RESP: begin
				if (err_rd ? rready : bready) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			live <= 1'b0;
			err_rd <= 1'b0;
		end else begin
			state <= state_nxt;
			live <= 1'b1;
			if (wr_take || rd_take) begin
				err_rd <= rd_take;
			end
		end
	end

	// payload capture
	always_ff @(posedge clk) begin
		if (wr_take) begin
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
		if (wr_take || rd_take) begin
			idx_q <= req_addr[IDX_W+2:3];
			resp_q <= req_ok ? OKAY : SLVERR;
		end
		// bad read returns zero data
		if (rd_take && !req_ok) begin
			rdata_q <= '0;
		end else if (state == RD_DATA) begin
			rdata_q <= mem_rdata;
		end
	end

	// request side
	assign arready = idle && !(awvalid && wvalid);
	assign awready = idle;
	assign wready = idle;

	// timer only for accesses that reach the array
	assign tmr_start = (wr_take || rd_take) && req_ok;

	// array strobes, one cycle each
	assign mem_we = (state == WR_WAIT) && tmr_done;
	assign mem_widx = idx_q;
	assign mem_wdata = wdata_q;
	assign mem_wstrb = wstrb_q;
	assign mem_re = (state == RD_WAIT) && tmr_done;
	assign mem_ridx = idx_q;

	// response side, all from registers
	assign rvalid = (state == RD_RESP) || ((state == ERR_RESP) && err_rd);
	assign bvalid = (state == WR_RESP) || ((state == ERR_RESP) && !err_rd);
	assign rdata = rdata_q;
	assign rresp = resp_q;
	assign bresp = resp_q;

	// response held with its payload until taken
	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp));

	// one transaction at a time
	a_one_resp: assert property (@(posedge clk) disable iff (rst)
		!(rvalid && bvalid));

endmodule

/* hdl/axi_sram_top.sv */
`timescale 1ns/1ps

module axi_sram_top
	import sram_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	// read address channel
	input  logic              arvalid,
	input  logic [ADDR_W-1:0] araddr,
	output logic              arready,
	// read data channel
	output logic              rvalid,
	output logic [DATA_W-1:0] rdata,
	output resp_t             rresp,
	input  logic              rready,
	// write address and data
	input  logic              awvalid,
	input  logic [ADDR_W-1:0] awaddr,
	output logic              awready,
	input  logic              wvalid,
	input  logic [DATA_W-1:0] wdata,
	input  logic [STRB_W-1:0] wstrb,
	output logic              wready,
	// write response channel
	output logic              bvalid,
	output resp_t             bresp,
	input  logic              bready
);

	// controller to timer
	logic tmr_start;
	logic tmr_done;
	// controller to array
	logic mem_we;
	logic [IDX_W-1:0] mem_widx;
	logic [DATA_W-1:0] mem_wdata;
	logic [STRB_W-1:0] mem_wstrb;
	logic mem_re;
	logic [IDX_W-1:0] mem_ridx;
	logic [DATA_W-1:0] mem_rdata;

	// transaction FSM, bus facing
	sram_ctrl sram_ctrl_i (
		.clk       (clk),
		.rst       (rst),
		.arvalid   (arvalid),
		.araddr    (araddr),
		.arready   (arready),
		.rvalid    (rvalid),
		.rdata     (rdata),
		.rresp     (rresp),
		.rready    (rready),
		.awvalid   (awvalid),
		.awaddr    (awaddr),
		.awready   (awready),
		.wvalid    (wvalid),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wready    (wready),
		.bvalid    (bvalid),
		.bresp     (bresp),
		.bready    (bready),
		.tmr_start (tmr_start),
		.tmr_done  (tmr_done),
		.mem_we    (mem_we),
		.mem_widx  (mem_widx),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_re    (mem_re),
		.mem_ridx  (mem_ridx),
		.mem_rdata (mem_rdata)
	);

	// fixed access latency
	wait_timer wait_timer_i (
		.clk   (clk),
		.rst   (rst),
		.start (tmr_start),
		.done  (tmr_done)
	);

	// storage
	sram_array sram_array_i (
		.clk   (clk),
		.we    (mem_we),
		.widx  (mem_widx),
		.wdata (mem_wdata),
		.wstrb (mem_wstrb),
		.re    (mem_re),
		.ridx  (mem_ridx),
		.rdata (mem_rdata)
	);

endmodule

/* bench/axi_tasks.svh */
`ifndef AXI_TASKS_SVH
`define AXI_TASKS_SVH

// compare one value against its expected value
task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
	if (actual !== expected) begin
		$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		stop_with_failure();
	end
endtask

// response phase on r or b
// stall counts from the first valid cycle
task automatic take_response(input bit is_read, input logic [ADDR_W-1:0] addr,
		input bit stall_on, output logic [DATA_W-1:0] data, output resp_t resp);
	int cnt;
	int stall;
	stall = stall_on ? int'($urandom_range(0, 5)) : 0;
	rready = is_read && (stall == 0);
	bready = !is_read && (stall == 0);
	// cycle 1 starts at the request transfer edge
	cnt = 1;
	@(negedge clk);
	while (!(is_read ? rvalid : bvalid)) begin
		cnt++;
		if (cnt > TIMEOUT) begin
			report_timeout(is_read ? "read response (rvalid)" : "write response (bvalid)");
		end
		@(negedge clk);
	end
	check_value("response latency", 64'(expected_latency(addr, is_read)), 64'(cnt));
	data = is_read ? rdata : '0;
	resp = is_read ? rresp : bresp;
	// held response must not move while ready is low
	while (stall > 0) begin
		@(posedge clk);
		#1;
		stall--;
		rready = is_read && (stall == 0);
		bready = !is_read && (stall == 0);
		@(negedge clk);
		check_value(is_read ? "rvalid" : "bvalid", 64'(1), 64'(is_read ? rvalid : bvalid));
		if (is_read) begin
			check_value("rdata", data, rdata);
		end
		check_value(is_read ? "rresp" : "bresp", 64'(resp), 64'(is_read ? rresp : bresp));
	end
	// transfer edge
	@(posedge clk);
	#1;
	rready = 1'b0;
	bready = 1'b0;
endtask

// one write with address and data together
task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb, input bit stall_on, output resp_t resp);
	int cnt;
	logic [DATA_W-1:0] unused_data;
	awvalid = 1'b1;
	awaddr = addr;
	wvalid = 1'b1;
	wdata = data;
	wstrb = strb;
	cnt = 0;
	@(negedge clk);
	while (!(awready && wready)) begin
		cnt++;
		if (cnt > TIMEOUT) begin
			report_timeout("write request (awready/wready)");
		end
		@(negedge clk);
	end
	// priority check looks at this
	arready_at_write = arready;
	@(posedge clk);
	#1;
	awvalid = 1'b0;
	wvalid = 1'b0;
	take_response(1'b0, addr, stall_on, unused_data, resp);
endtask

// one read
task automatic bus_read(input logic [ADDR_W-1:0] addr, input bit stall_on,
		output logic [DATA_W-1:0] data, output resp_t resp);
	int cnt;
	arvalid = 1'b1;
	araddr = addr;
	cnt = 0;
	@(negedge clk);
	while (!arready) begin
		cnt++;
		if (cnt > TIMEOUT) begin
			report_timeout("read request (arready)");
		end
		@(negedge clk);
	end
	@(posedge clk);
	#1;
	arvalid = 1'b0;
	take_response(1'b1, addr, stall_on, data, resp);
endtask

`endif

/* bench/tb_axi_sram.sv */
`timescale 1ns/1ps

module tb_axi_sram
	import sram_pkg::*;
();

	localparam int TIMEOUT = 200;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_OPS = 200;

	logic clk;
	logic rst;
	logic arvalid;
	logic [ADDR_W-1:0] araddr;
	logic arready;
	logic rvalid;
	logic [DATA_W-1:0] rdata;
	resp_t rresp;
	logic rready;
	logic awvalid;
	logic [ADDR_W-1:0] awaddr;
	logic awready;
	logic wvalid;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic wready;
	logic bvalid;
	resp_t bresp;
	logic bready;

	// reference memory, word index to word
	logic [DATA_W-1:0] model [int];
	// word indices written with full strobes
	int written [$];
	logic arready_at_write;

	axi_sram_top axi_sram_top_i (
		.clk     (clk),
		.rst     (rst),
		.arvalid (arvalid),
		.araddr  (araddr),
		.arready (arready),
		.rvalid  (rvalid),
		.rdata   (rdata),
		.rresp   (rresp),
		.rready  (rready),
		.awvalid (awvalid),
		.awaddr  (awaddr),
		.awready (awready),
		.wvalid  (wvalid),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wready  (wready),
		.bvalid  (bvalid),
		.bresp   (bresp),
		.bready  (bready)
	);

	// 100 ns period
	always #50 clk = ~clk;

	task automatic stop_with_failure();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s handshake hung for %0d cycles", what, TIMEOUT);
		stop_with_failure();
	endtask

	// aligned and inside the 4 KiB window
	function automatic bit addr_ok(input logic [ADDR_W-1:0] addr);
		return (addr[2:0] == 3'b000) && (addr < ADDR_W'(MEM_WORDS * 8));
	endfunction

	// cycles from the request transfer edge to the visible valid
	function automatic int expected_latency(input logic [ADDR_W-1:0] addr, input bit is_read);
		if (!addr_ok(addr)) begin
			return 1;
		end
		return is_read ? ACCESS_WAIT + 2 : ACCESS_WAIT + 1;
	endfunction

	// only strobed bytes take the new value
	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
			input logic [DATA_W-1:0] nxt, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] res;
		res = old;
		for (int b = 0; b < STRB_W; b++) begin
			if (strb[b]) begin
				res[b*8 +: 8] = nxt[b*8 +: 8];
			end
		end
		return res;
	endfunction

	`include "axi_tasks.svh"

	task automatic write_and_model(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic [STRB_W-1:0] strb, input bit stall_on);
		resp_t resp;
		int idx;
		bus_write(addr, data, strb, stall_on, resp);
		check_value("bresp", 64'(addr_ok(addr) ? OKAY : SLVERR), 64'(resp));
		if (addr_ok(addr)) begin
			idx = int'(addr >> 3);
			model[idx] = merge_bytes(model.exists(idx) ? model[idx] : '0, data, strb);
		end
	endtask

	task automatic read_and_compare(input logic [ADDR_W-1:0] addr, input bit stall_on);
		logic [DATA_W-1:0] data;
		resp_t resp;
		bus_read(addr, stall_on, data, resp);
		check_value("rresp", 64'(addr_ok(addr) ? OKAY : SLVERR), 64'(resp));
		if (!addr_ok(addr)) begin
			check_value("rdata", '0, data);
		end else if (model.exists(int'(addr >> 3))) begin
			check_value("rdata", model[int'(addr >> 3)], data);
		end
	endtask

	initial begin
		int idx;
		logic [ADDR_W-1:0] addr;
		void'($urandom(32'h34e4));
		clk = 1'b0;
		rst = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;

		// reset, and the first edge after it, keep the bus quiet
		for (int i = 0; i <= RESET_CYCLES; i++) begin
			@(negedge clk);
			check_value("rvalid", 64'(0), 64'(rvalid));
			check_value("bvalid", 64'(0), 64'(bvalid));
			check_value("arready", 64'(0), 64'(arready));
			check_value("awready", 64'(0), 64'(awready));
			check_value("wready", 64'(0), 64'(wready));
			if (i == RESET_CYCLES - 1) begin
				@(posedge clk);
				#1;
				rst = 1'b0;
			end
		end
		@(negedge clk);
		check_value("arready", 64'(1), 64'(arready));
		check_value("awready", 64'(1), 64'(awready));
		@(posedge clk);
		#1;

		// full word writes then read back
		for (int n = 0; n < NUM_OPS; n++) begin
			idx = int'($urandom_range(0, MEM_WORDS - 1));
			if (!model.exists(idx)) begin
				written.push_back(idx);
			end
			write_and_model(ADDR_W'(idx * 8), {$urandom, $urandom}, '1, 1'b1);
		end
		foreach (written[k]) begin
			read_and_compare(ADDR_W'(written[k] * 8), 1'b1);
		end

		// partial strobes over known words
		for (int n = 0; n < NUM_OPS; n++) begin
			idx = written[$urandom_range(0, written.size() - 1)];
			write_and_model(ADDR_W'(idx * 8), {$urandom, $urandom},
				STRB_W'($urandom_range(0, 255)), 1'b1);
			read_and_compare(ADDR_W'(idx * 8), 1'b1);
		end

		// out of window and misaligned, no array access
		for (int n = 0; n < 20; n++) begin
			addr = ADDR_W'(MEM_WORDS * 8 + int'($urandom_range(0, 4095)) * 8);
			write_and_model(addr, {$urandom, $urandom}, '1, 1'b1);
			read_and_compare(addr, 1'b1);
			addr = ADDR_W'(int'($urandom_range(0, MEM_WORDS - 1)) * 8 + int'($urandom_range(1, 7)));
			write_and_model(addr, {$urandom, $urandom}, '1, 1'b1);
			read_and_compare(addr, 1'b1);
		end
		foreach (model[i]) begin
			read_and_compare(ADDR_W'(i * 8), 1'b1);
		end

		// ready held high, latency checked inside the tasks
		for (int n = 0; n < 10; n++) begin
			idx = int'($urandom_range(0, MEM_WORDS - 1));
			write_and_model(ADDR_W'(idx * 8), {$urandom, $urandom}, '1, 1'b0);
			read_and_compare(ADDR_W'(idx * 8), 1'b0);
		end

		// read and write raised together, write goes first
		idx = int'($urandom_range(0, MEM_WORDS - 1));
		arvalid = 1'b1;
		araddr = ADDR_W'(idx * 8);
		write_and_model(ADDR_W'(idx * 8), {$urandom, $urandom}, '1, 1'b0);
		check_value("arready", 64'(0), 64'(arready_at_write));
		// read still pending, must return the new word
		read_and_compare(ADDR_W'(idx * 8), 1'b0);

		$display("PASS: all tests");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+bench
hdl/sram_pkg.sv
hdl/wait_timer.sv
hdl/sram_array.sv
hdl/sram_ctrl.sv
hdl/axi_sram_top.sv
bench/tb_axi_sram.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_axi_sram -o sim_tb \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 && ! grep -q "FAIL: see errors above" sim.log \
	&& echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
